// File: concat_trace.txt
# W branch(1-5) first_word(hex) count gap : count words, one per cycle, then gap cycles
#   gap 0 starts the next record on the same cycle
# E first_word(hex) branch(1-5) count last : count expected words, last on the final one
# F overflow(hex) : wait for outputs to drain, then compare the overflow bits
F 00
# frame 1, groups complete from branch 5 down to branch 1
W 5 00005000 4 4
W 4 00004000 4 4
W 3 00003000 4 4
# branch 2 stores a second group for frame 2
W 2 00002000 8 8
# branch 1 one word short, nothing may come out yet
W 1 00001000 3 12
E 00001000 1 4 0
E 00002000 2 4 0
E 00003000 3 4 0
E 00004000 4 4 0
E 00005000 5 4 1
W 1 00001003 1 1
F 00
# frame 2, all branches write on the same cycles
# branch 2 sends its stored second group first
E 00001010 1 4 0
E 00002004 2 4 0
E 00003010 3 4 0
E 00004010 4 4 0
E 00005010 5 4 1
W 1 00001010 4 0
W 2 00002010 4 0
W 3 00003010 4 0
W 4 00004010 4 0
W 5 00005010 4 4
F 00
# branch 3 gets 17 words while the arbiter waits on branch 1, the 17th is dropped
W 3 00003100 17 20
F 04
# frames 3 to 6, branch 3 drains its 16 stored words
E 00001100 1 4 0
E 00002010 2 4 0
E 00003100 3 4 0
E 00004100 4 4 0
E 00005100 5 4 1
E 00001104 1 4 0
E 00002014 2 4 0
E 00003104 3 4 0
E 00004104 4 4 0
E 00005104 5 4 1
E 00001108 1 4 0
E 00002018 2 4 0
E 00003108 3 4 0
E 00004108 4 4 0
E 00005108 5 4 1
E 0000110c 1 4 0
E 0000201c 2 4 0
E 0000310c 3 4 0
E 0000410c 4 4 0
E 0000510c 5 4 1
W 1 00001100 16 0
W 2 00002014 12 0
W 4 00004100 16 0
W 5 00005100 16 16
F 04
# quiet tail, the dropped word must never show up
W 1 00000000 0 30

// File: filelist.f
concat_pkg.sv
branch_buffer.sv
concat_arbiter.sv
cnn_concat_5in.sv
tb_cnn_concat_5in.sv

// File: tb_cnn_concat_5in.sv
`timescale 1ns/1ps

module tb_cnn_concat_5in;

  import concat_pkg::*;

  //////////////////////////////
  // tb constants

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  // bound on one wait, in clock cycles
  localparam int WAIT_LIMIT   = 500;
  localparam TRACE_FILE       = "concat_trace.txt";

  logic                  clk;
  logic                  reset;
  logic                  valid_drv [NUM_BRANCH];
  data_t                 word_drv  [NUM_BRANCH];
  data_t                 out;
  logic                  valid_out;
  branch_idx_t           out_branch;
  logic                  last_out;
  logic [NUM_BRANCH-1:0] overflow;

  // per-branch write runs still being played out
  data_t run_data [NUM_BRANCH];
  int    run_left [NUM_BRANCH];

  // expected output stream, in order
  data_t       exp_data_q[$];
  branch_idx_t exp_branch_q[$];
  logic        exp_last_q[$];

  int errors;
  int words_seen;

  cnn_concat_5in cnn_concat_5in_i (
    .clk          (clk),
    .reset        (reset),
    .valid_in_no1 (valid_drv[0]),
    .in_no1       (word_drv[0]),
    .valid_in_no2 (valid_drv[1]),
    .in_no2       (word_drv[1]),
    .valid_in_no3 (valid_drv[2]),
    .in_no3       (word_drv[2]),
    .valid_in_no4 (valid_drv[3]),
    .in_no4       (word_drv[3]),
    .valid_in_no5 (valid_drv[4]),
    .in_no5       (word_drv[4]),
    .out          (out),
    .valid_out    (valid_out),
    .out_branch   (out_branch),
    .last_out     (last_out),
    .overflow     (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // compare helpers

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_branch(input string name, input branch_idx_t got,
                              input branch_idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_overflow(input logic [NUM_BRANCH-1:0] exp);
    for (int k = 0; k < NUM_BRANCH; k++) begin
      check_flag($sformatf("overflow[%0d]", k), overflow[k], exp[k]);
    end
  endtask

  //////////////////////////////
  // stimulus helpers

  // drive one word per busy branch on this falling edge, then move to the next one
  task automatic tick();
    for (int k = 0; k < NUM_BRANCH; k++) begin
      if (run_left[k] > 0) begin
        valid_drv[k] = 1'b1;
        word_drv[k]  = run_data[k];
        run_data[k]  = run_data[k] + 1;
        run_left[k]  = run_left[k] - 1;
      end else begin
        valid_drv[k] = 1'b0;
      end
    end
    @(negedge clk);
  endtask

  function automatic logic runs_busy();
    logic busy;
    busy = 1'b0;
    for (int k = 0; k < NUM_BRANCH; k++) begin
      if (run_left[k] > 0) begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  // all writes played out and every expected word seen
  task automatic wait_drained(output logic timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    while ((exp_data_q.size() != 0 || runs_busy()) && cycles < WAIT_LIMIT) begin
      tick();
      cycles++;
    end
    if (exp_data_q.size() != 0 || runs_busy()) begin
      $display("timed out after %0d cycles, %0d expected output words still missing",
               WAIT_LIMIT, exp_data_q.size());
      errors++;
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////
  // output monitor

  initial begin
    forever begin
      @(negedge clk);
      if (!reset && valid_out) begin
        words_seen++;
        if (exp_data_q.size() == 0) begin
          $display("output word 0x%h from branch %0d arrived with no trace entry left",
                   out, out_branch + 1);
          errors++;
        end else begin
          check_data("out", out, exp_data_q.pop_front());
          check_branch("out_branch", out_branch, exp_branch_q.pop_front());
          check_flag("last_out", last_out, exp_last_q.pop_front());
        end
      end else if (!reset && last_out) begin
        $display("last_out was high on a cycle without valid_out");
        errors++;
      end
    end
  end

  //////////////////////////////
  // trace player

  initial begin
    int                    fd;
    int                    c;
    int                    n;
    int                    branch;
    int                    count;
    int                    gap;
    int                    last;
    data_t                 word;
    logic [NUM_BRANCH-1:0] ovf_exp;
    logic                  abort;

    errors     = 0;
    words_seen = 0;
    abort      = 1'b0;
    reset      = 1'b1;
    for (int k = 0; k < NUM_BRANCH; k++) begin
      valid_drv[k] = 1'b0;
      word_drv[k]  = '0;
      run_data[k]  = '0;
      run_left[k]  = 0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // idle straight out of reset
    check_flag("valid_out", valid_out, 1'b0);
    check_flag("last_out", last_out, 1'b0);
    check_overflow('0);

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open trace file %s", TRACE_FILE);
      errors++;
      abort = 1'b1;
    end
    while (!abort && !$feof(fd)) begin
      c = $fgetc(fd);
      if (c == "#") begin
        // comment runs to end of line
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c == "W") begin
        n = $fscanf(fd, "%d %h %d %d", branch, word, count, gap);
        if (n != 4 || branch < 1 || branch > NUM_BRANCH) begin
          $display("malformed write record in the trace file");
          errors++;
          abort = 1'b1;
        end else begin
          run_data[branch-1] = word;
          run_left[branch-1] = count;
          // gap 0 keeps the next record on this same cycle
          repeat (gap) tick();
        end
      end else if (c == "E") begin
        n = $fscanf(fd, "%h %d %d %d", word, branch, count, last);
        if (n != 4 || branch < 1 || branch > NUM_BRANCH) begin
          $display("malformed expect record in the trace file");
          errors++;
          abort = 1'b1;
        end else begin
          for (int i = 0; i < count; i++) begin
            exp_data_q.push_back(word + i);
            exp_branch_q.push_back(branch_idx_t'(branch - 1));
            exp_last_q.push_back((last != 0) && (i == count - 1));
          end
        end
      end else if (c == "F") begin
        n = $fscanf(fd, "%h", ovf_exp);
        if (n != 1) begin
          $display("malformed flag record in the trace file");
          errors++;
          abort = 1'b1;
        end else begin
          wait_drained(abort);
          if (!abort) begin
            check_overflow(ovf_exp);
          end
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!abort && exp_data_q.size() != 0) begin
      $display("%0d expected output words never appeared", exp_data_q.size());
      errors++;
    end

    $display("words checked: %0d, errors: %0d", words_seen, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: cnn_concat_5in.sv
`timescale 1ns/1ps

module cnn_concat_5in (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              valid_in_no1,
  input  concat_pkg::data_t                 in_no1,
  input  logic                              valid_in_no2,
  input  concat_pkg::data_t                 in_no2,
  input  logic                              valid_in_no3,
  input  concat_pkg::data_t                 in_no3,
  input  logic                              valid_in_no4,
  input  concat_pkg::data_t                 in_no4,
  input  logic                              valid_in_no5,
  input  concat_pkg::data_t                 in_no5,
  output concat_pkg::data_t                 out,
  output logic                              valid_out,
  output concat_pkg::branch_idx_t           out_branch,
  output logic                              last_out,
  output logic [concat_pkg::NUM_BRANCH-1:0] overflow
);

  import concat_pkg::*;

  //////////////////////////////
  // buffer to arbiter wiring

  // one bit per branch, bit 0 is branch 1
  logic [NUM_BRANCH-1:0] req;
  logic [NUM_BRANCH-1:0] ack;
  logic [NUM_BRANCH-1:0] pop;

  // fifo heads
  data_t rd_data0;
  data_t rd_data1;
  data_t rd_data2;
  data_t rd_data3;
  data_t rd_data4;

  //////////////////////////////
  // per-branch buffers

  // branch 1
  branch_buffer buf_no1 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in_no1),
    .in       (in_no1),
    .pop      (pop[0]),
    .ack      (ack[0]),
    .req      (req[0]),
    .rd_data  (rd_data0),
    .overflow (overflow[0])
  );

  // branch 2
  branch_buffer buf_no2 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in_no2),
    .in       (in_no2),
    .pop      (pop[1]),
    .ack      (ack[1]),
    .req      (req[1]),
    .rd_data  (rd_data1),
    .overflow (overflow[1])
  );

  // branch 3
  branch_buffer buf_no3 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in_no3),
    .in       (in_no3),
    .pop      (pop[2]),
    .ack      (ack[2]),
    .req      (req[2]),
    .rd_data  (rd_data2),
    .overflow (overflow[2])
  );

  // branch 4
  branch_buffer buf_no4 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in_no4),
    .in       (in_no4),
    .pop      (pop[3]),
    .ack      (ack[3]),
    .req      (req[3]),
    .rd_data  (rd_data3),
    .overflow (overflow[3])
  );

  // branch 5, its last word ends the frame
  branch_buffer buf_no5 (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in_no5),
    .in       (in_no5),
    .pop      (pop[4]),
    .ack      (ack[4]),
    .req      (req[4]),
    .rd_data  (rd_data4),
    .overflow (overflow[4])
  );

  //////////////////////////////
  // ordered merge onto the output

  concat_arbiter arb (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .rd_data0   (rd_data0),
    .rd_data1   (rd_data1),
    .rd_data2   (rd_data2),
    .rd_data3   (rd_data3),
    .rd_data4   (rd_data4),
    .ack        (ack),
    .pop        (pop),
    .out        (out),
    .valid_out  (valid_out),
    .out_branch (out_branch),
    .last_out   (last_out)
  );

endmodule

// File: concat_arbiter.sv
`timescale 1ns/1ps

module concat_arbiter (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [concat_pkg::NUM_BRANCH-1:0] req,
  input  concat_pkg::data_t                 rd_data0,
  input  concat_pkg::data_t                 rd_data1,
  input  concat_pkg::data_t                 rd_data2,
  input  concat_pkg::data_t                 rd_data3,
  input  concat_pkg::data_t                 rd_data4,
  output logic [concat_pkg::NUM_BRANCH-1:0] ack,
  output logic [concat_pkg::NUM_BRANCH-1:0] pop,
  output concat_pkg::data_t                 out,
  output logic                              valid_out,
  output concat_pkg::branch_idx_t           out_branch,
  output logic                              last_out
);

  import concat_pkg::*;

  //////////////////////////////
  // grant state

  arb_state_t               state;
  // branch in turn moves on only once its ack is down
  branch_idx_t              cur;
  branch_idx_t              next_branch;
  logic [GRP_CNT_WIDTH-1:0] pop_cnt;

  logic  group_done;
  logic  frame_end;
  data_t sel_data;

  // one-hot of the branch acked last
  // seeds to branch 5 so that branch 1 comes first
  logic [NUM_BRANCH-1:0] last_grant;

  // last pop of the current group
  assign group_done = (state == ARB_STREAM) && (pop_cnt == GRP_CNT_WIDTH'(GROUP_LEN - 1));

  // branch 5 closes the frame
  assign frame_end = group_done && (cur == branch_idx_t'(NUM_BRANCH - 1));

  // fixed channel order 0..4 then wrap
  assign next_branch = (cur == branch_idx_t'(NUM_BRANCH - 1)) ? '0 : cur + 1'b1;

  // one pop per cycle on the acked branch while streaming
  assign pop = (state == ARB_STREAM) ? ack : '0;

  //////////////////////////////
  // fsm
  // group to group spacing is 3 cycles
  // release cycle, ack low cycle, then next ack with its first pop

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ARB_WAIT_REQ;
      cur     <= '0;
      ack     <= '0;
      pop_cnt <= '0;
    end else begin
      case (state)
        ARB_WAIT_REQ: begin
          // later branches may be ready but still wait their turn
          if (req[cur]) begin
            ack     <= NUM_BRANCH'(1) << cur;
            pop_cnt <= '0;
            state   <= ARB_STREAM;
          end
        end
        ARB_STREAM: begin
          pop_cnt <= pop_cnt + 1'b1;
          if (group_done) begin
            state <= ARB_RELEASE;
          end
        end
        ARB_RELEASE: begin
          // wait for the buffer to drop req after its last pop
          if (!req[cur]) begin
            ack   <= '0;
            cur   <= next_branch;
            state <= ARB_WAIT_REQ;
          end
        end
        default: begin
          state <= ARB_WAIT_REQ;
        end
      endcase
    end
  end

  //////////////////////////////
  // shared read bus

  always_comb begin
    case (cur)
      3'd0:    sel_data = rd_data0;
      3'd1:    sel_data = rd_data1;
      3'd2:    sel_data = rd_data2;
      3'd3:    sel_data = rd_data3;
      3'd4:    sel_data = rd_data4;
      default: sel_data = '0;
    endcase
  end

  // word popped in cycle t shows on out in t+1
  always_ff @(posedge clk) begin
    if (|pop) begin
      out        <= sel_data;
      out_branch <= cur;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      last_out  <= 1'b0;
    end else begin
      valid_out <= |pop;
      last_out  <= frame_end;
    end
  end

  //////////////////////////////
  // checks

  // remember the most recent grant
  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= NUM_BRANCH'(1) << (NUM_BRANCH - 1);
    end else if (ack != '0) begin
      last_grant <= ack;
    end
  end

  // one grant at a time on the shared bus
  a_ack_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(ack));

  // a new ack goes to the branch right after the last one granted
  a_ack_in_order: assert property (@(posedge clk) disable iff (reset)
    ((ack & ~$past(ack)) != '0) |->
      (ack == {last_grant[NUM_BRANCH-2:0], last_grant[NUM_BRANCH-1]}));

endmodule

// File: branch_buffer.sv
`timescale 1ns/1ps

module branch_buffer (
  input  logic              clk,
  input  logic              reset,
  input  logic              valid_in,
  input  concat_pkg::data_t in,
  input  logic              pop,
  input  logic              ack,
  output logic              req,
  output concat_pkg::data_t rd_data,
  output logic              overflow
);

  import concat_pkg::*;

  //////////////////////////////
  // storage

  data_t                    mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]     wr_ptr;
  logic [PTR_WIDTH-1:0]     rd_ptr;
  logic [CNT_WIDTH-1:0]     count;

  // words handed to the arbiter in the current grant
  logic [GRP_CNT_WIDTH-1:0] sent;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;
  logic last_pop;

  assign full  = (count == CNT_WIDTH'(FIFO_DEPTH));
  assign empty = (count == '0);

  // no input stall, a word hitting a full buffer is just lost
  assign wr_en = valid_in && !full;
  assign rd_en = pop && !empty;

  // final pop of this group
  assign last_pop = rd_en && ack && (sent == GRP_CNT_WIDTH'(GROUP_LEN - 1));

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in;
    end
  end

  // head of fifo, valid whenever not empty
  assign rd_data = mem[rd_ptr];

  //////////////////////////////
  // pointers and occupancy

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at FIFO_DEPTH
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // write plus pop in one cycle keeps count
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // buffer side of req/ack

  always_ff @(posedge clk) begin
    if (reset) begin
      sent <= '0;
    end else if (!ack) begin
      sent <= '0;
    end else if (rd_en) begin
      // wraps back to 0 on the last pop
      sent <= sent + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req <= 1'b0;
    end else if (last_pop) begin
      // drop req one cycle after the last pop
      req <= 1'b0;
    end else if (!req && !ack && (count >= CNT_WIDTH'(GROUP_LEN))) begin
      // a whole group is stored and previous ack is gone
      req <= 1'b1;
    end
  end

  // sticky loss flag
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (valid_in && full) begin
      overflow <= 1'b1;
    end
  end

  //////////////////////////////
  // checks

  // arbiter only pops the buffer it granted
  a_pop_with_ack: assert property (@(posedge clk) disable iff (reset)
    pop |-> ack);

  // a grant never drains more than what was stored when req rose
  a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

  // arbiter has released this buffer before a new request
  a_req_rise_idle: assert property (@(posedge clk) disable iff (reset)
    $rose(req) |-> !ack);

endmodule

// File: concat_pkg.sv
package concat_pkg;

  //////////////////////////////
  // data path sizes

  // pixel word width
  localparam int DATA_WIDTH = 32;

  // branches feeding the concat stage
  localparam int NUM_BRANCH = 5;
  localparam int BRANCH_IDX_WIDTH = 3;

  //////////////////////////////
  // buffering

  // words per branch per frame
  localparam int GROUP_LEN = 4;
  localparam int GRP_CNT_WIDTH = $clog2(GROUP_LEN);

  // per-branch fifo, power of two so pointers wrap for free
  localparam int FIFO_DEPTH = 16;
  localparam int PTR_WIDTH = 4;

  // occupancy needs one extra bit to hold FIFO_DEPTH itself
  localparam int CNT_WIDTH = PTR_WIDTH + 1;

  //////////////////////////////
  // types

  // one pixel
  typedef logic [DATA_WIDTH-1:0] data_t;

  // branch number, 0 is branch 1 of the top level
  typedef logic [BRANCH_IDX_WIDTH-1:0] branch_idx_t;

  // arbiter fsm
  // wait for current branch req, stream its group, then close the handshake
  typedef enum logic [1:0] {
    ARB_WAIT_REQ = 2'd0,
    ARB_STREAM   = 2'd1,
    ARB_RELEASE  = 2'd2
  } arb_state_t;

endpackage
